/* hdl/norm_check_config.svh */
`ifndef NORM_CHECK_CONFIG_SVH
`define NORM_CHECK_CONFIG_SVH

// Polynomial size and the ML-DSA modulus
`define NC_N            256
`define NC_Q            8380417
`define NC_COEFF_W      24

// Each memory word carries four coefficient lanes
`define NC_LANES        4
`define NC_LANE_W       2

// Two polynomials of 64 words each fit in the memory
`define NC_MEM_DEPTH    128
`define NC_ADDR_W       7

// Two words are read per cycle, so a polynomial is 32 word pairs
`define NC_PAIRS        32
`define NC_PAIR_W       5

// Norm bounds for the three check modes
`define NC_BOUND_Z      524168
`define NC_BOUND_R0     261768
`define NC_BOUND_CT0    261888

`endif

/* hdl/norm_check_pkg.sv */
`default_nettype none

package norm_check_pkg;

    // Check mode as written to CONFIG bits 1:0
    typedef enum logic [1:0] {
        MODE_Z   = 2'd0,
        MODE_R0  = 2'd1,
        MODE_CT0 = 2'd2
    } chk_mode_e;

    // Read sequencer states
    typedef enum logic [1:0] {
        CHK_IDLE   = 2'd0,
        CHK_RD_MEM = 2'd1,
        CHK_FLUSH  = 2'd2,
        CHK_DONE   = 2'd3
    } chk_read_state_e;

endpackage

`default_nettype wire

/* hdl/coeff_mem.sv */
`timescale 1ns/100ps
`default_nettype none
`include "norm_check_config.svh"

module coeff_mem (
    input  wire                                clk,
    input  wire                                wr_en,
    input  wire  [`NC_ADDR_W-1:0]              wr_addr,
    input  wire  [`NC_LANE_W-1:0]              wr_lane,
    input  wire  [`NC_COEFF_W-1:0]             wr_data,
    input  wire                                rd_en,
    input  wire  [`NC_ADDR_W-1:0]              rd_addr_a,
    input  wire  [`NC_ADDR_W-1:0]              rd_addr_b,
    output logic [`NC_LANES*`NC_COEFF_W-1:0]   rd_data_a,
    output logic [`NC_LANES*`NC_COEFF_W-1:0]   rd_data_b
);

    // Lane 0 sits in the low bits of each word
    logic [`NC_LANES-1:0][`NC_COEFF_W-1:0] mem [`NC_MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr][wr_lane] <= wr_data;
        end
    end

    // Both ports read together, one for the even word and one for the odd word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data_a <= mem[rd_addr_a];
            rd_data_b <= mem[rd_addr_b];
        end
    end

endmodule

`default_nettype wire

/* hdl/norm_check_regs.sv */
`timescale 1ns/100ps
`default_nettype none
`include "norm_check_config.svh"

module norm_check_regs (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire                        awvalid,
    input  wire  [7:0]                 awaddr,
    input  wire                        wvalid,
    input  wire  [31:0]                wdata,
    input  wire                        bready,
    input  wire                        arvalid,
    input  wire  [7:0]                 araddr,
    input  wire                        rready,
    output logic                       awready,
    output logic                       wready,
    output logic                       bvalid,
    output logic [1:0]                 bresp,
    output logic                       arready,
    output logic                       rvalid,
    output logic [1:0]                 rresp,
    output logic [31:0]                rdata,
    output logic                       start,
    output logic                       zeroize,
    output norm_check_pkg::chk_mode_e  mode,
    output logic [`NC_ADDR_W-1:0]      base_addr,
    output logic [`NC_PAIR_W-1:0]      randomness,
    output logic                       wr_en,
    output logic [`NC_ADDR_W-1:0]      wr_addr,
    output logic [`NC_LANE_W-1:0]      wr_lane,
    output logic [`NC_COEFF_W-1:0]     wr_data,
    input  wire                        busy,
    input  wire                        done,
    input  wire                        invalid
);
    import norm_check_pkg::*;

    localparam logic [7:0] OFS_CTRL        = 8'h00;
    localparam logic [7:0] OFS_CONFIG      = 8'h04;
    localparam logic [7:0] OFS_STATUS      = 8'h08;
    localparam logic [7:0] OFS_COEFF_INDEX = 8'h0C;
    localparam logic [7:0] OFS_COEFF_DATA  = 8'h10;
    localparam int         IDX_W           = `NC_ADDR_W + `NC_LANE_W;

    logic             wr_acc;
    logic             rd_acc;
    logic             done_sticky;
    logic [IDX_W-1:0] coeff_idx;
    logic [31:0]      rd_word;

    // Address and data are taken together, and only with no response pending
    assign wr_acc  = awvalid && wvalid && !bvalid;
    assign rd_acc  = arvalid && !rvalid;
    assign awready = wr_acc;
    assign wready  = wr_acc;
    assign arready = !rvalid;
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;

    // Coefficient writes go straight to the memory lane that the index points at
    assign wr_en   = wr_acc && (awaddr == OFS_COEFF_DATA);
    assign wr_addr = coeff_idx[IDX_W-1:`NC_LANE_W];
    assign wr_lane = coeff_idx[`NC_LANE_W-1:0];
    assign wr_data = wdata[`NC_COEFF_W-1:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            rdata  <= 32'h0;
        end else begin
            if (wr_acc) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_acc) begin
                rvalid <= 1'b1;
                rdata  <= rd_word;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // CTRL bits become one-cycle pulses in the cycle after the write
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            start   <= 1'b0;
            zeroize <= 1'b0;
        end else begin
            start   <= wr_acc && (awaddr == OFS_CTRL) && wdata[0];
            zeroize <= wr_acc && (awaddr == OFS_CTRL) && wdata[1];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mode       <= MODE_Z;
            base_addr  <= '0;
            randomness <= '0;
        end else if (wr_acc && (awaddr == OFS_CONFIG)) begin
            mode       <= chk_mode_e'(wdata[1:0]);
            base_addr  <= wdata[8 +: `NC_ADDR_W];
            randomness <= wdata[16 +: `NC_PAIR_W];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            coeff_idx   <= '0;
            done_sticky <= 1'b0;
        end else if (zeroize) begin
            coeff_idx   <= '0;
            done_sticky <= 1'b0;
        end else begin
            if (wr_acc && (awaddr == OFS_COEFF_INDEX)) begin
                coeff_idx <= wdata[IDX_W-1:0];
            end else if (wr_en) begin
                coeff_idx <= coeff_idx + 1'b1;
            end
            // A new start clears the previous result before the pulse can set it
            if (start) begin
                done_sticky <= 1'b0;
            end else if (done) begin
                done_sticky <= 1'b1;
            end
        end
    end

    always_comb begin
        rd_word = 32'h0;
        case (araddr)
            OFS_CONFIG: begin
                rd_word[1:0]                = mode;
                rd_word[8 +: `NC_ADDR_W]    = base_addr;
                rd_word[16 +: `NC_PAIR_W]   = randomness;
            end
            OFS_STATUS:      rd_word[2:0]       = {invalid, done_sticky, busy};
            OFS_COEFF_INDEX: rd_word[IDX_W-1:0] = coeff_idx;
            default:         rd_word            = 32'h0;
        endcase
    end

    // A write response only ever follows an accepted write
    a_bvalid_after_write: assert property (
        @(posedge clk) disable iff (!reset_n)
        $rose(bvalid) |-> $past(wr_acc)
    );

endmodule

`default_nettype wire

/* hdl/norm_check_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none
`include "norm_check_config.svh"

module norm_check_ctrl (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire                    zeroize,
    input  wire                    start,
    input  wire  [`NC_ADDR_W-1:0]  base_addr,
    input  wire  [`NC_PAIR_W-1:0]  randomness,
    output logic                   rd_en,
    output logic [`NC_ADDR_W-1:0]  rd_addr_a,
    output logic [`NC_ADDR_W-1:0]  rd_addr_b,
    output logic                   check_enable,
    output logic                   clear,
    output logic                   busy,
    output logic                   done
);
    import norm_check_pkg::*;

    localparam int ADDR_W = `NC_ADDR_W;
    localparam int PAIR_W = `NC_PAIR_W;

    chk_read_state_e   state;
    chk_read_state_e   state_nxt;
    logic [ADDR_W-1:0] base_q;
    logic [PAIR_W-1:0] pair_idx;
    logic [PAIR_W-1:0] pair_cnt;
    logic              last_pair;
    logic              launch;

    // A start is only taken when the sequencer is idle
    assign launch    = start && (state == CHK_IDLE);
    assign last_pair = (pair_cnt == PAIR_W'(`NC_PAIRS - 1));

    assign busy      = (state != CHK_IDLE);
    assign rd_en     = (state == CHK_RD_MEM);
    assign rd_addr_a = base_q + ADDR_W'({pair_idx, 1'b0});
    assign rd_addr_b = rd_addr_a + ADDR_W'(1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= CHK_IDLE;
        end else if (zeroize) begin
            state <= CHK_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            CHK_IDLE:   state_nxt = launch ? CHK_RD_MEM : CHK_IDLE;
            CHK_RD_MEM: state_nxt = last_pair ? CHK_FLUSH : CHK_RD_MEM;
            // One cycle for the last read data to reach the checker
            CHK_FLUSH:  state_nxt = CHK_DONE;
            CHK_DONE:   state_nxt = CHK_IDLE;
            default:    state_nxt = CHK_IDLE;
        endcase
    end

    // The pair index starts at the random offset and wraps over the polynomial
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            base_q   <= '0;
            pair_idx <= '0;
            pair_cnt <= '0;
        end else if (zeroize) begin
            base_q   <= '0;
            pair_idx <= '0;
            pair_cnt <= '0;
        end else if (launch) begin
            base_q   <= base_addr;
            pair_idx <= randomness;
            pair_cnt <= '0;
        end else if (rd_en) begin
            pair_idx <= pair_idx + 1'b1;
            pair_cnt <= pair_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            check_enable <= 1'b0;
            clear        <= 1'b0;
            done         <= 1'b0;
        end else if (zeroize) begin
            check_enable <= 1'b0;
            clear        <= 1'b0;
            done         <= 1'b0;
        end else begin
            check_enable <= rd_en;
            clear        <= launch;
            done         <= (state == CHK_DONE);
        end
    end

    a_rd_en_busy: assert property (
        @(posedge clk) disable iff (!reset_n)
        rd_en |-> busy
    );

    a_done_not_reading: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(done && rd_en)
    );

endmodule

`default_nettype wire

/* hdl/norm_bound_checker.sv */
`timescale 1ns/100ps
`default_nettype none
`include "norm_check_config.svh"

module norm_bound_checker (
    input  wire                               clk,
    input  wire                               reset_n,
    input  wire                               zeroize,
    input  wire                               clear,
    input  wire                               check_enable,
    input  norm_check_pkg::chk_mode_e         mode,
    input  wire  [`NC_LANES*`NC_COEFF_W-1:0]  rd_data_a,
    input  wire  [`NC_LANES*`NC_COEFF_W-1:0]  rd_data_b,
    output logic                              invalid
);
    import norm_check_pkg::*;

    localparam int                 LANES   = `NC_LANES;
    localparam int                 COEFF_W = `NC_COEFF_W;
    localparam logic [COEFF_W-1:0] Q       = `NC_Q;
    localparam logic [COEFF_W-1:0] HALF_Q  = (`NC_Q - 1) / 2;

    logic [COEFF_W-1:0] bound;
    logic [2*LANES-1:0] lane_fail;

    // Values at or above q are not reduced and always fail
    function automatic logic coeff_fails(
        input logic [COEFF_W-1:0] c,
        input logic [COEFF_W-1:0] b
    );
        logic [COEFF_W-1:0] mag;
        if (c >= Q) begin
            return 1'b1;
        end
        mag = (c <= HALF_Q) ? c : Q - c;
        return (mag >= b);
    endfunction

    always_comb begin
        case (mode)
            MODE_Z:   bound = COEFF_W'(`NC_BOUND_Z);
            MODE_R0:  bound = COEFF_W'(`NC_BOUND_R0);
            MODE_CT0: bound = COEFF_W'(`NC_BOUND_CT0);
            default:  bound = COEFF_W'(`NC_BOUND_R0);
        endcase
    end

    // Lanes 0 to 3 come from the even word, lanes 4 to 7 from the odd word
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane_fail[i]         = coeff_fails(rd_data_a[i*COEFF_W +: COEFF_W], bound);
            lane_fail[LANES + i] = coeff_fails(rd_data_b[i*COEFF_W +: COEFF_W], bound);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            invalid <= 1'b0;
        end else if (zeroize || clear) begin
            invalid <= 1'b0;
        end else if (check_enable && (|lane_fail)) begin
            invalid <= 1'b1;
        end
    end

    // The clear pulse always lands before the first checked data of a run
    a_clear_before_check: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(check_enable && clear)
    );

endmodule

`default_nettype wire

/* hdl/norm_check_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "norm_check_config.svh"

module norm_check_top (
    input  wire          clk,
    input  wire          reset_n,
    input  wire          awvalid,
    input  wire  [7:0]   awaddr,
    input  wire          wvalid,
    input  wire  [31:0]  wdata,
    input  wire          bready,
    input  wire          arvalid,
    input  wire  [7:0]   araddr,
    input  wire          rready,
    output logic         awready,
    output logic         wready,
    output logic         bvalid,
    output logic [1:0]   bresp,
    output logic         arready,
    output logic         rvalid,
    output logic [1:0]   rresp,
    output logic [31:0]  rdata
);
    import norm_check_pkg::*;

    logic                              start;
    logic                              zeroize;
    chk_mode_e                         mode;
    logic [`NC_ADDR_W-1:0]             base_addr;
    logic [`NC_PAIR_W-1:0]             randomness;
    logic                              wr_en;
    logic [`NC_ADDR_W-1:0]             wr_addr;
    logic [`NC_LANE_W-1:0]             wr_lane;
    logic [`NC_COEFF_W-1:0]            wr_data;
    logic                              rd_en;
    logic [`NC_ADDR_W-1:0]             rd_addr_a;
    logic [`NC_ADDR_W-1:0]             rd_addr_b;
    logic [`NC_LANES*`NC_COEFF_W-1:0]  rd_data_a;
    logic [`NC_LANES*`NC_COEFF_W-1:0]  rd_data_b;
    logic                              check_enable;
    logic                              clear;
    logic                              busy;
    logic                              done;
    logic                              invalid;

    norm_check_regs norm_check_regs_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .bready     (bready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .rready     (rready),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid),
        .bresp      (bresp),
        .arready    (arready),
        .rvalid     (rvalid),
        .rresp      (rresp),
        .rdata      (rdata),
        .start      (start),
        .zeroize    (zeroize),
        .mode       (mode),
        .base_addr  (base_addr),
        .randomness (randomness),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_lane    (wr_lane),
        .wr_data    (wr_data),
        .busy       (busy),
        .done       (done),
        .invalid    (invalid)
    );

    norm_check_ctrl norm_check_ctrl_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .start        (start),
        .base_addr    (base_addr),
        .randomness   (randomness),
        .rd_en        (rd_en),
        .rd_addr_a    (rd_addr_a),
        .rd_addr_b    (rd_addr_b),
        .check_enable (check_enable),
        .clear        (clear),
        .busy         (busy),
        .done         (done)
    );

    coeff_mem coeff_mem_i (
        .clk       (clk),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_lane   (wr_lane),
        .wr_data   (wr_data),
        .rd_en     (rd_en),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    norm_bound_checker norm_bound_checker_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .clear        (clear),
        .check_enable (check_enable),
        .mode         (mode),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .invalid      (invalid)
    );

endmodule

`default_nettype wire

/* test/norm_check_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "norm_check_config.svh"

module norm_check_tb;

    localparam int          NUM_VEC     = 17;
    localparam int          NUM_COEFF   = `NC_MEM_DEPTH * `NC_LANES;
    localparam int          HS_LIMIT    = 20;
    localparam int          POLL_LIMIT  = 200;
    localparam logic [31:0] NO_CORRUPT  = 32'hfff;
    localparam logic [31:0] CONFIG_MASK = 32'h001f_7f03;
    localparam logic [7:0]  REG_CTRL    = 8'h00;
    localparam logic [7:0]  REG_CONFIG  = 8'h04;
    localparam logic [7:0]  REG_STATUS  = 8'h08;
    localparam logic [7:0]  REG_INDEX   = 8'h0C;
    localparam logic [7:0]  REG_DATA    = 8'h10;

    logic        clk;
    logic        reset_n;
    logic        awvalid;
    logic [7:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic        bready;
    logic        arvalid;
    logic [7:0]  araddr;
    logic        rready;
    wire         awready;
    wire         wready;
    wire         bvalid;
    wire  [1:0]  bresp;
    wire         arready;
    wire         rvalid;
    wire  [1:0]  rresp;
    wire  [31:0] rdata;

    logic [31:0]            vec [NUM_VEC*5];
    logic [`NC_COEFF_W-1:0] model_mem [NUM_COEFF];
    logic [31:0]            lcg_state;

    norm_check_top norm_check_top_i (
        .clk     (clk),
        .reset_n (reset_n),
        .awvalid (awvalid),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wdata   (wdata),
        .bready  (bready),
        .arvalid (arvalid),
        .araddr  (araddr),
        .rready  (rready),
        .awready (awready),
        .wready  (wready),
        .bvalid  (bvalid),
        .bresp   (bresp),
        .arready (arready),
        .rvalid  (rvalid),
        .rresp   (rresp),
        .rdata   (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int unsigned mode_bound(input int unsigned m);
        case (m)
            0: return `NC_BOUND_Z;
            1: return `NC_BOUND_R0;
            default: return `NC_BOUND_CT0;
        endcase
    endfunction

    // Centered magnitude against the mode bound, values at or above q are never legal
    function automatic logic coeff_out_of_bound(input int unsigned c, input int unsigned m);
        int unsigned mag;
        if (c >= `NC_Q) begin
            return 1'b1;
        end
        mag = (c > (`NC_Q - 1) / 2) ? `NC_Q - c : c;
        return mag >= mode_bound(m);
    endfunction

    // Scans the 64 words of the polynomial at base, with 7-bit address wrap
    function automatic logic expected_invalid(input int unsigned m, input int unsigned base);
        int unsigned word;
        logic        result;
        result = 1'b0;
        for (int w = 0; w < 2 * `NC_PAIRS; w++) begin
            word = (base + w) % `NC_MEM_DEPTH;
            for (int l = 0; l < `NC_LANES; l++) begin
                if (coeff_out_of_bound(model_mem[word * `NC_LANES + l], m)) begin
                    result = 1'b1;
                end
            end
        end
        return result;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        int n;
        n = 0;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        // Address and data are taken together at the rising edge that sees awready
        @(posedge clk);
        while (!awready) begin
            n++;
            if (n > HS_LIMIT) begin
                fail_run($sformatf("Write to register 0x%02h was never accepted", addr));
            end
            @(posedge clk);
        end
        check_value("wready", 32'(wready), 32'h1);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid) begin
            n++;
            if (n > HS_LIMIT) begin
                fail_run($sformatf("No write response for register 0x%02h", addr));
            end
            @(negedge clk);
        end
        check_value("bresp", 32'(bresp), 32'h0);
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
        int n;
        n = 0;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        @(posedge clk);
        while (!arready) begin
            n++;
            if (n > HS_LIMIT) begin
                fail_run($sformatf("Read of register 0x%02h was never accepted", addr));
            end
            @(posedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            n++;
            if (n > HS_LIMIT) begin
                fail_run($sformatf("No read data for register 0x%02h", addr));
            end
            @(negedge clk);
        end
        data = rdata;
        check_value("rresp", 32'(rresp), 32'h0);
    endtask

    // The index register should have stepped past the written lane
    task automatic write_coeff(input int unsigned idx, input logic [31:0] value);
        logic [31:0] rd;
        axi_write(REG_INDEX, idx);
        axi_write(REG_DATA, value);
        model_mem[idx] = value[`NC_COEFF_W-1:0];
        axi_read(REG_INDEX, rd);
        check_value("COEFF_INDEX", rd, (idx + 1) % NUM_COEFF);
    endtask

    // In-bound values with magnitude 1 to BOUND_R0-2, odd indices stored as q - v
    task automatic fill_memory();
        int unsigned v;
        int unsigned c;
        lcg_state = 32'hc1c7_4f18;
        axi_write(REG_INDEX, 32'h0);
        for (int i = 0; i < NUM_COEFF; i++) begin
            lcg_state = lcg_next(lcg_state);
            v = 1 + (lcg_state >> 8) % (`NC_BOUND_R0 - 2);
            c = (i % 2 == 1) ? `NC_Q - v : v;
            model_mem[i] = c;
            axi_write(REG_DATA, c);
        end
    endtask

    task automatic wait_done(output logic [31:0] status);
        int n;
        n = 0;
        axi_read(REG_STATUS, status);
        while (!status[1]) begin
            n++;
            if (n > POLL_LIMIT) begin
                fail_run("STATUS.done never came up after a start");
            end
            axi_read(REG_STATUS, status);
        end
    endtask

    task automatic run_check(input int unsigned m, input int unsigned base,
                             input int unsigned rnd);
        logic [31:0] status;
        axi_write(REG_CONFIG, (rnd << 16) | (base << 8) | m);
        axi_write(REG_CTRL, 32'h1);
        wait_done(status);
        check_value("STATUS.busy", 32'(status[0]), 32'h0);
        check_value("STATUS.invalid", 32'(status[2]), 32'(expected_invalid(m, base)));
    endtask

    initial begin
        logic [31:0]            rd;
        logic [31:0]            cfg;
        logic [31:0]            idx;
        logic [`NC_COEFF_W-1:0] orig;
        reset_n = 1'b0;
        awvalid = 1'b0;
        awaddr  = 8'h0;
        wvalid  = 1'b0;
        wdata   = 32'h0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = 8'h0;
        rready  = 1'b0;
        $readmemh("test/norm_check_vectors.hex", vec);
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        axi_read(REG_STATUS, rd);
        check_value("STATUS", rd, 32'h0);
        cfg = 32'h5a5a_a5a6;
        axi_write(REG_CONFIG, cfg);
        axi_read(REG_CONFIG, rd);
        check_value("CONFIG", rd, cfg & CONFIG_MASK);

        fill_memory();

        // Each vector corrupts at most one coefficient and restores it afterwards
        for (int v = 0; v < NUM_VEC; v++) begin
            idx = vec[5*v + 3];
            if (idx != NO_CORRUPT) begin
                orig = model_mem[idx];
                write_coeff(idx, vec[5*v + 4]);
            end
            run_check(vec[5*v], vec[5*v + 1], vec[5*v + 2]);
            if (idx != NO_CORRUPT) begin
                write_coeff(idx, orig);
            end
        end

        // Word 9 sits in pair 4 of polynomial 0
        orig = model_mem[37];
        write_coeff(37, `NC_BOUND_R0);
        axi_write(REG_CONFIG, (3 << 16) | 1);
        axi_write(REG_CTRL, 32'h1);
        axi_read(REG_STATUS, rd);
        check_value("STATUS.busy_done", 32'(rd[1:0]), 32'h1);
        // A restart on the clean second polynomial would report valid
        axi_write(REG_CONFIG, (3 << 16) | ((2 * `NC_PAIRS) << 8) | 1);
        axi_write(REG_CTRL, 32'h1);
        wait_done(rd);
        check_value("STATUS.invalid", 32'(rd[2]), 32'(expected_invalid(1, 0)));

        // Zeroize in the middle of a run
        axi_write(REG_CONFIG, (3 << 16) | 1);
        axi_write(REG_CTRL, 32'h1);
        axi_read(REG_STATUS, rd);
        check_value("STATUS.busy", 32'(rd[0]), 32'h1);
        axi_write(REG_CTRL, 32'h2);
        axi_read(REG_STATUS, rd);
        check_value("STATUS", rd, 32'h0);
        run_check(1, 0, 3);
        write_coeff(37, orig);
        run_check(2, 0, 0);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* test/norm_check_vectors.hex */
// Columns: mode base_word randomness corrupt_index corrupt_value
// corrupt_index is the coefficient index in memory, fff means no corruption
0 00 00 fff 000000
1 00 05 fff 000000
2 00 1f fff 000000
// Single corrupt coefficient over every lane, even and odd words
1 00 00 000 03fe88
1 00 0a 005 03fe88
2 00 03 00a 03fe88
0 00 11 00f 03fe88
1 00 1f 0ff 7fe000
2 00 07 083 03ff00
0 00 14 0c6 07ff88
1 00 02 041 7be179
0 00 09 0fc 7fe001
// Same corruption under different rotations
1 00 00 07a 03fe88
1 00 0d 07a 03fe88
1 00 1f 07a 03fe88
// Corruption in the second polynomial only
0 00 06 12c 07ff88
0 40 06 12c 07ff88

/* vlog.f */
+incdir+hdl
hdl/norm_check_pkg.sv
hdl/coeff_mem.sv
hdl/norm_check_regs.sv
hdl/norm_check_ctrl.sv
hdl/norm_bound_checker.sv
hdl/norm_check_top.sv
test/norm_check_tb.sv
